//--- rtl/vchan_mem_pkg.sv
/*
 * Shared widths, port count and channel payload types for the virtual-channel
 * memory multiplexer. Imported by every RTL and testbench module.
 */
package vchan_mem_pkg;

    // ==============================
    // Sizes
    // ==============================

    localparam int NUM_PORTS   = 4;
    localparam int ADDR_WIDTH  = 32;
    localparam int DATA_WIDTH  = 64;
    localparam int LEN_WIDTH   = 4;
    localparam int VCHAN_WIDTH = $clog2(NUM_PORTS);
    // Port tag sits in the low bits of the user field
    localparam int USER_WIDTH  = 4;
    localparam int STRB_WIDTH  = DATA_WIDTH / 8;
    localparam int RESP_WIDTH  = 2;

    typedef logic [ADDR_WIDTH-1:0]  t_addr;
    typedef logic [DATA_WIDTH-1:0]  t_data;
    typedef logic [LEN_WIDTH-1:0]   t_len;
    typedef logic [VCHAN_WIDTH-1:0] t_vchan;
    typedef logic [USER_WIDTH-1:0]  t_user;
    typedef logic [RESP_WIDTH-1:0]  t_resp;

    // ==============================
    // Channel payloads
    // ==============================

    typedef struct packed {
        t_addr addr;
        t_len  len;    // Beats minus one
        t_user user;
    } t_ar_chan;

    typedef struct packed {
        t_data data;
        t_resp resp;
        logic  last;
        t_user user;
    } t_r_chan;

    typedef struct packed {
        t_addr addr;
        t_len  len;
        t_user user;
    } t_aw_chan;

    typedef struct packed {
        t_data                 data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } t_w_chan;

    typedef struct packed {
        t_resp resp;
        t_user user;
    } t_b_chan;

    // Merged write beat whose aw only matters on the first beat of a burst
    typedef struct packed {
        t_aw_chan aw;
        t_w_chan  w;
    } t_wr_beat;

endpackage

//--- rtl/vchan_arbiter.sv
/*
 * Round-robin arbiter merging per-port valid/ready streams into one registered
 * stream. The grant stays with a port until its last beat has been taken.
 */
module vchan_arbiter
    import vchan_mem_pkg::*;
#(
    parameter type t_payload = logic
) (
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic [NUM_PORTS-1:0] in_valid,
    input  logic [NUM_PORTS-1:0] in_last,
    input  t_payload             in_data [NUM_PORTS],
    output logic [NUM_PORTS-1:0] in_ready,

    output logic                 out_valid,
    output t_payload             out_data,
    output t_vchan               out_vchan,
    output logic                 out_last,
    input  logic                 out_ready
);

    // Most recent winner and owner of the grant while locked
    t_vchan last_grant;
    logic   locked;

    t_vchan rr_pick;
    logic   rr_found;
    t_vchan sel;
    logic   sel_valid;
    logic   load;

    // ==============================
    // Grant selection
    // ==============================

    // Walk down from the farthest port so the nearest requester after
    // last_grant is the one left standing
    always_comb begin
        int idx;
        rr_pick  = last_grant;
        rr_found = 1'b0;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            idx = (int'(last_grant) + i) % NUM_PORTS;
            if (in_valid[idx]) begin
                rr_pick  = t_vchan'(idx);
                rr_found = 1'b1;
            end
        end
    end

    always_comb begin
        if (locked) begin
            sel       = last_grant;
            sel_valid = in_valid[last_grant];
        end else begin
            sel       = rr_pick;
            sel_valid = rr_found;
        end
    end

    // Output register refills in the same cycle it drains
    assign load = sel_valid && (!out_valid || out_ready);

    always_comb begin
        in_ready = '0;
        if (load) begin
            in_ready[sel] = 1'b1;
        end
    end

    // ==============================
    // State and output register
    // ==============================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid  <= 1'b0;
            locked     <= 1'b0;
            last_grant <= t_vchan'(NUM_PORTS - 1);
        end else begin
            if (load) begin
                out_valid  <= 1'b1;
                locked     <= !in_last[sel];
                last_grant <= sel;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_data  <= in_data[sel];
            out_vchan <= sel;
            out_last  <= in_last[sel];
        end
    end

endmodule

//--- rtl/vchan_demux.sv
/*
 * Combinational demultiplexer for a response stream. The port tag picks which
 * output sees valid; payload is broadcast to all outputs.
 */
module vchan_demux
    import vchan_mem_pkg::*;
#(
    parameter type t_payload = logic
) (
    input  logic                 in_valid,
    input  t_payload             in_data,
    input  t_vchan               in_vchan,
    output logic                 in_ready,

    output logic [NUM_PORTS-1:0] out_valid,
    output t_payload             out_data [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] out_ready
);

    // Host side waits on the addressed port only
    assign in_ready = out_ready[in_vchan];

    always_comb begin
        out_valid = '0;
        if (in_valid) begin
            out_valid[in_vchan] = 1'b1;
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            out_data[p] = in_data;
        end
    end

endmodule

//--- rtl/vchan_write_merge.sv
/*
 * Joins one port's AW and W channels into a single write beat stream so that
 * bursts can be arbitrated as a unit. AW rides along only on the first beat.
 */
module vchan_write_merge
    import vchan_mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,

    input  logic     aw_valid,
    input  t_aw_chan aw,
    output logic     aw_ready,

    input  logic     w_valid,
    input  t_w_chan  w,
    output logic     w_ready,

    output logic     beat_valid,
    output t_wr_beat beat,
    output logic     beat_last,
    input  logic     beat_ready
);

    // High when the next W beat opens a new burst
    logic sop;

    // A burst's first beat needs its AW as well
    assign beat_valid = w_valid && (aw_valid || !sop);
    assign aw_ready   = beat_ready && w_valid && sop;
    assign w_ready    = beat_ready && (aw_valid || !sop);

    always_comb begin
        beat.w  = w;
        beat.aw = sop ? aw : '0;
    end

    assign beat_last = w.last;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            sop <= 1'b1;
        end else if (w_valid && w_ready) begin
            sop <= w.last;
        end
    end

endmodule

//--- rtl/vchan_write_split.sv
/*
 * Splits the merged write beat stream back into host AW and W. The host may
 * take AW and W in different cycles; a beat retires once both parts are done.
 */
module vchan_write_split
    import vchan_mem_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,

    input  logic     beat_valid,
    input  t_wr_beat beat,
    output logic     beat_ready,

    output logic     aw_valid,
    output t_aw_chan aw,
    input  logic     aw_ready,

    output logic     w_valid,
    output t_w_chan  w,
    input  logic     w_ready
);

    logic aw_done;
    logic w_done;
    logic sop;

    // AW exists only at the start of a burst
    assign aw_valid = beat_valid && sop && !aw_done;
    assign w_valid  = beat_valid && !w_done;

    assign beat_ready = (aw_ready || aw_done || !sop) && (w_ready || w_done);

    assign aw = beat.aw;
    assign w  = beat.w;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            sop     <= 1'b1;
        end else if (beat_valid && beat_ready) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            sop     <= beat.w.last;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_done <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_done <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/vchan_mem_mux.sv
/*
 * Virtual-channel multiplexer: NUM_PORTS accelerator memory ports share one host
 * port. Requests are tagged with their source port, replies route back by tag.
 */
module vchan_mem_mux
    import vchan_mem_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    // Accelerator ports
    input  logic [NUM_PORTS-1:0] afu_ar_valid,
    input  t_ar_chan             afu_ar [NUM_PORTS],
    output logic [NUM_PORTS-1:0] afu_ar_ready,
    input  logic [NUM_PORTS-1:0] afu_aw_valid,
    input  t_aw_chan             afu_aw [NUM_PORTS],
    output logic [NUM_PORTS-1:0] afu_aw_ready,
    input  logic [NUM_PORTS-1:0] afu_w_valid,
    input  t_w_chan              afu_w [NUM_PORTS],
    output logic [NUM_PORTS-1:0] afu_w_ready,
    output logic [NUM_PORTS-1:0] afu_r_valid,
    output t_r_chan              afu_r [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] afu_r_ready,
    output logic [NUM_PORTS-1:0] afu_b_valid,
    output t_b_chan              afu_b [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] afu_b_ready,

    // Host port
    output logic                 host_ar_valid,
    output t_ar_chan             host_ar,
    input  logic                 host_ar_ready,
    output logic                 host_aw_valid,
    output t_aw_chan             host_aw,
    input  logic                 host_aw_ready,
    output logic                 host_w_valid,
    output t_w_chan              host_w,
    input  logic                 host_w_ready,
    input  logic                 host_r_valid,
    input  t_r_chan              host_r,
    output logic                 host_r_ready,
    input  logic                 host_b_valid,
    input  t_b_chan              host_b,
    output logic                 host_b_ready
);

    // ==============================
    // Reads
    // ==============================

    t_ar_chan ar_arb_data;
    t_vchan   ar_arb_vchan;
    t_vchan   r_vchan;

    // AR is never a burst so every request is its own last beat
    vchan_arbiter #(.t_payload(t_ar_chan)) ar_arb (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (afu_ar_valid),
        .in_last   ({NUM_PORTS{1'b1}}),
        .in_data   (afu_ar),
        .in_ready  (afu_ar_ready),
        .out_valid (host_ar_valid),
        .out_data  (ar_arb_data),
        .out_vchan (ar_arb_vchan),
        .out_last  (),
        .out_ready (host_ar_ready)
    );

    always_comb begin
        host_ar      = ar_arb_data;
        host_ar.user = t_user'(ar_arb_vchan);
    end

    assign r_vchan = host_r.user[VCHAN_WIDTH-1:0];

    vchan_demux #(.t_payload(t_r_chan)) r_demux (
        .in_valid  (host_r_valid),
        .in_data   (host_r),
        .in_vchan  (r_vchan),
        .in_ready  (host_r_ready),
        .out_valid (afu_r_valid),
        .out_data  (afu_r),
        .out_ready (afu_r_ready)
    );

    // ==============================
    // Writes
    // ==============================

    logic [NUM_PORTS-1:0] beat_valid;
    logic [NUM_PORTS-1:0] beat_last;
    logic [NUM_PORTS-1:0] beat_ready;
    t_wr_beat             beat [NUM_PORTS];

    t_wr_beat wr_arb_data;
    t_wr_beat wr_tagged;
    t_vchan   wr_arb_vchan;
    logic     wr_arb_valid;
    logic     wr_arb_ready;
    t_vchan   b_vchan;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_merge
        vchan_write_merge merge_i (
            .clk        (clk),
            .reset_n    (reset_n),
            .aw_valid   (afu_aw_valid[p]),
            .aw         (afu_aw[p]),
            .aw_ready   (afu_aw_ready[p]),
            .w_valid    (afu_w_valid[p]),
            .w          (afu_w[p]),
            .w_ready    (afu_w_ready[p]),
            .beat_valid (beat_valid[p]),
            .beat       (beat[p]),
            .beat_last  (beat_last[p]),
            .beat_ready (beat_ready[p])
        );
    end

    // Grant held until w.last so bursts never interleave
    vchan_arbiter #(.t_payload(t_wr_beat)) wr_arb (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (beat_valid),
        .in_last   (beat_last),
        .in_data   (beat),
        .in_ready  (beat_ready),
        .out_valid (wr_arb_valid),
        .out_data  (wr_arb_data),
        .out_vchan (wr_arb_vchan),
        .out_last  (),
        .out_ready (wr_arb_ready)
    );

    always_comb begin
        wr_tagged         = wr_arb_data;
        wr_tagged.aw.user = t_user'(wr_arb_vchan);
    end

    vchan_write_split split_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .beat_valid (wr_arb_valid),
        .beat       (wr_tagged),
        .beat_ready (wr_arb_ready),
        .aw_valid   (host_aw_valid),
        .aw         (host_aw),
        .aw_ready   (host_aw_ready),
        .w_valid    (host_w_valid),
        .w          (host_w),
        .w_ready    (host_w_ready)
    );

    assign b_vchan = host_b.user[VCHAN_WIDTH-1:0];

    vchan_demux #(.t_payload(t_b_chan)) b_demux (
        .in_valid  (host_b_valid),
        .in_data   (host_b),
        .in_vchan  (b_vchan),
        .in_ready  (host_b_ready),
        .out_valid (afu_b_valid),
        .out_data  (afu_b),
        .out_ready (afu_b_ready)
    );

endmodule

//--- verification/tb_clock_gen.sv
/*
 * Testbench clock and reset source. Makes a 20 ns clock and holds reset_n low
 * for the first five rising edges, releasing it on an edge.
 */
module tb_clock_gen (
    output logic clk,
    output logic reset_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time PERIOD       = 20ns;
    localparam int  RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

//--- verification/vchan_mem_properties.sv
/*
 * Concurrent checks on the host-side request channels of the memory mux.
 * Bound into every vchan_mem_mux instance.
 */
module vchan_mem_properties
    import vchan_mem_pkg::*;
(
    input logic     clk,
    input logic     reset_n,
    input logic     host_ar_valid,
    input logic     host_ar_ready,
    input t_ar_chan host_ar,
    input logic     host_aw_valid,
    input logic     host_aw_ready,
    input t_aw_chan host_aw,
    input logic     host_w_valid,
    input logic     host_w_ready,
    input t_w_chan  host_w
);
    timeunit 1ns;
    timeprecision 1ps;

    // AW count may never run ahead of the completed bursts
    int aw_cnt;
    int last_cnt;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            aw_cnt   <= 0;
            last_cnt <= 0;
        end else begin
            if (host_aw_valid && host_aw_ready) begin
                aw_cnt <= aw_cnt + 1;
            end
            if (host_w_valid && host_w_ready && host_w.last) begin
                last_cnt <= last_cnt + 1;
            end
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
        host_ar_valid && !host_ar_ready |=> host_ar_valid && $stable(host_ar))
        else $error("host AR dropped or changed before ready");
    a_aw_hold: assert property (@(posedge clk) disable iff (!reset_n)
        host_aw_valid && !host_aw_ready |=> host_aw_valid && $stable(host_aw))
        else $error("host AW dropped or changed before ready");
    a_w_hold: assert property (@(posedge clk) disable iff (!reset_n)
        host_w_valid && !host_w_ready |=> host_w_valid && $stable(host_w))
        else $error("host W dropped or changed before ready");
    a_aw_first: assert property (@(posedge clk) disable iff (!reset_n)
        host_aw_valid |-> aw_cnt <= last_cnt)
        else $error("host AW offered inside a burst");
    a_reset_idle: assert property (@(posedge clk)
        $rose(reset_n) |-> !host_ar_valid && !host_aw_valid && !host_w_valid)
        else $error("host valid high right after reset");

endmodule

bind vchan_mem_mux vchan_mem_properties props_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .host_ar_valid (host_ar_valid),
    .host_ar_ready (host_ar_ready),
    .host_ar       (host_ar),
    .host_aw_valid (host_aw_valid),
    .host_aw_ready (host_aw_ready),
    .host_aw       (host_aw),
    .host_w_valid  (host_w_valid),
    .host_w_ready  (host_w_ready),
    .host_w        (host_w)
);

//--- verification/vchan_mem_tb.sv
/*
 * Testbench for the virtual-channel memory mux with a host memory model, port
 * drivers and directed tests. Run with the top module vchan_mem_tb.
 */
module vchan_mem_tb
    import vchan_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Beats moved by the five tests in order
    localparam int TEST_BEATS      = 2 + 4 + 16 + NUM_PORTS * 2 * (1 + 2 + 3 + 4) + 1;
    localparam int CYCLES_PER_BEAT = 50;

    logic                 clk;
    logic                 reset_n;
    logic [NUM_PORTS-1:0] afu_ar_valid;
    t_ar_chan             afu_ar [NUM_PORTS];
    logic [NUM_PORTS-1:0] afu_ar_ready;
    logic [NUM_PORTS-1:0] afu_aw_valid;
    t_aw_chan             afu_aw [NUM_PORTS];
    logic [NUM_PORTS-1:0] afu_aw_ready;
    logic [NUM_PORTS-1:0] afu_w_valid;
    t_w_chan              afu_w [NUM_PORTS];
    logic [NUM_PORTS-1:0] afu_w_ready;
    logic [NUM_PORTS-1:0] afu_r_valid;
    t_r_chan              afu_r [NUM_PORTS];
    logic [NUM_PORTS-1:0] afu_r_ready = '1;
    logic [NUM_PORTS-1:0] afu_b_valid;
    t_b_chan              afu_b [NUM_PORTS];
    logic [NUM_PORTS-1:0] afu_b_ready = '1;
    logic                 host_ar_valid;
    t_ar_chan             host_ar;
    logic                 host_ar_ready = 1'b1;
    logic                 host_aw_valid;
    t_aw_chan             host_aw;
    logic                 host_aw_ready = 1'b1;
    logic                 host_w_valid;
    t_w_chan              host_w;
    logic                 host_w_ready = 1'b1;
    logic                 host_r_valid = 1'b0;
    t_r_chan              host_r = '0;
    logic                 host_r_ready;
    logic                 host_b_valid = 1'b0;
    t_b_chan              host_b = '0;
    logic                 host_b_ready;

    // Host memory model state and logs of host-side transfers
    t_data    mem [t_addr];
    t_data    ref_mem [t_addr];
    t_ar_chan ar_q[$];
    t_aw_chan aw_q[$];
    t_w_chan  w_q[$];
    t_b_chan  b_q[$];
    t_ar_chan ar_log[$];
    int       ar_cycle[$];
    t_aw_chan aw_log[$];
    t_w_chan  w_log[$];
    t_r_chan  r_got [NUM_PORTS][$];
    t_b_chan  b_got [NUM_PORTS][$];
    int       r_idx = 0;
    int       w_idx = 0;
    int       cycle = 0;
    logic     throttle = 1'b0;
    integer   seed = 32'h3240;
    logic [31:0] rnd;

    tb_clock_gen clk_gen_i (.clk(clk), .reset_n(reset_n));

    vchan_mem_mux dut_i (.*);

    // ==============================
    // Host memory model
    // ==============================

    always @(posedge clk) begin
        t_w_chan  wb;
        t_addr    wa;
        t_data    word;
        t_ar_chan ar;
        rnd = $random(seed);
        cycle <= cycle + 1;
        if (!reset_n) begin
            host_r_valid <= 1'b0;
            host_b_valid <= 1'b0;
        end else begin
            if (host_ar_valid && host_ar_ready) begin
                ar_q.push_back(host_ar);
                ar_log.push_back(host_ar);
                ar_cycle.push_back(cycle);
            end
            if (host_aw_valid && host_aw_ready) begin
                aw_q.push_back(host_aw);
                aw_log.push_back(host_aw);
            end
            if (host_w_valid && host_w_ready) begin
                w_q.push_back(host_w);
                w_log.push_back(host_w);
            end
            // W beats may arrive before their AW and are applied once both exist
            while (aw_q.size() > 0 && w_q.size() > 0) begin
                wb = w_q.pop_front();
                wa = aw_q[0].addr + t_addr'(w_idx * 8);
                word = mem.exists(wa) ? mem[wa] : '0;
                for (int b = 0; b < STRB_WIDTH; b++) begin
                    if (wb.strb[b]) begin
                        word[b*8 +: 8] = wb.data[b*8 +: 8];
                    end
                end
                mem[wa] = word;
                if (wb.last) begin
                    b_q.push_back('{resp: '0, user: aw_q[0].user});
                    aw_q.delete(0);
                    w_idx = 0;
                end else begin
                    w_idx++;
                end
            end
            if (host_r_valid && host_r_ready) begin
                if (host_r.last) begin
                    ar_q.delete(0);
                    r_idx = 0;
                end else begin
                    r_idx++;
                end
            end
            if (!host_r_valid || host_r_ready) begin
                if (ar_q.size() > 0 && (!throttle || rnd[3])) begin
                    ar = ar_q[0];
                    wa = ar.addr + t_addr'(r_idx * 8);
                    word = mem.exists(wa) ? mem[wa] : '0;
                    host_r_valid <= 1'b1;
                    host_r <= '{data: word, resp: '0, last: (r_idx == int'(ar.len)),
                                user: ar.user};
                end else begin
                    host_r_valid <= 1'b0;
                end
            end
            if (host_b_valid && host_b_ready) begin
                b_q.delete(0);
            end
            if (!host_b_valid || host_b_ready) begin
                if (b_q.size() > 0 && (!throttle || rnd[4])) begin
                    host_b_valid <= 1'b1;
                    host_b <= b_q[0];
                end else begin
                    host_b_valid <= 1'b0;
                end
            end
        end
        if (throttle) begin
            host_ar_ready <= rnd[0];
            host_aw_ready <= rnd[1];
            host_w_ready  <= rnd[2];
            afu_r_ready   <= rnd[11:8];
            afu_b_ready   <= rnd[15:12];
        end else begin
            host_ar_ready <= 1'b1;
            host_aw_ready <= 1'b1;
            host_w_ready  <= 1'b1;
            afu_r_ready   <= '1;
            afu_b_ready   <= '1;
        end
    end

    // Responses seen at each port
    always @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (afu_r_valid[p] && afu_r_ready[p]) begin
                r_got[p].push_back(afu_r[p]);
            end
            if (afu_b_valid[p] && afu_b_ready[p]) begin
                b_got[p].push_back(afu_b[p]);
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input t_data got, input t_data exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input t_resp got, input t_resp exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_vchan(input t_vchan got, input t_vchan exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_len(input t_len got, input t_len exp, input string name);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    // Word pattern carrying the writing port and the address
    function automatic t_data beat_word(input int p, input t_addr a);
        return {16'hC0DE, 14'h0, t_vchan'(p), a};
    endfunction

    // ==============================
    // Port drivers
    // ==============================

    task automatic send_ar(input int p, input t_addr a, input t_len len,
                           output int at_cycle);
        @(posedge clk);
        afu_ar_valid[p] <= 1'b1;
        afu_ar[p] <= '{addr: a, len: len, user: '0};
        do @(posedge clk); while (!afu_ar_ready[p]);
        at_cycle = cycle;
        afu_ar_valid[p] <= 1'b0;
    endtask

    task automatic send_aw(input int p, input t_addr a, input t_len len);
        @(posedge clk);
        afu_aw_valid[p] <= 1'b1;
        afu_aw[p] <= '{addr: a, len: len, user: '0};
        do @(posedge clk); while (!afu_aw_ready[p]);
        afu_aw_valid[p] <= 1'b0;
    endtask

    task automatic send_w(input int p, input t_addr a, input t_len len);
        @(posedge clk);
        for (int i = 0; i <= int'(len); i++) begin
            afu_w_valid[p] <= 1'b1;
            afu_w[p] <= '{data: beat_word(p, a + t_addr'(i * 8)), strb: '1,
                          last: (i == int'(len))};
            do @(posedge clk); while (!afu_w_ready[p]);
        end
        afu_w_valid[p] <= 1'b0;
    endtask

    task automatic write_burst(input int p, input t_addr a, input t_len len);
        t_b_chan b;
        fork
            send_aw(p, a, len);
            send_w(p, a, len);
        join
        for (int i = 0; i <= int'(len); i++) begin
            ref_mem[a + t_addr'(i * 8)] = beat_word(p, a + t_addr'(i * 8));
        end
        while (b_got[p].size() == 0) @(posedge clk);
        b = b_got[p].pop_front();
        check_resp(b.resp, 2'b00, $sformatf("afu_b[%0d].resp", p));
        check_vchan(b.user[VCHAN_WIDTH-1:0], t_vchan'(p), $sformatf("afu_b[%0d].user", p));
    endtask

    task automatic read_burst(input int p, input t_addr a, input t_len len,
                              output int at_cycle);
        t_r_chan r;
        t_addr   ra;
        send_ar(p, a, len, at_cycle);
        for (int i = 0; i <= int'(len); i++) begin
            while (r_got[p].size() == 0) @(posedge clk);
            r = r_got[p].pop_front();
            ra = a + t_addr'(i * 8);
            check_data(r.data, ref_mem[ra], $sformatf("afu_r[%0d].data @%h", p, ra));
            check_resp(r.resp, 2'b00, $sformatf("afu_r[%0d].resp", p));
            check_vchan(r.user[VCHAN_WIDTH-1:0], t_vchan'(p),
                        $sformatf("afu_r[%0d].user", p));
            if (r.last !== (i == int'(len))) begin
                report_failure($sformatf("Port %0d read burst has a wrong last flag", p));
            end
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic test_reset_and_single();
        int at;
        @(posedge clk);
        if (host_ar_valid || host_aw_valid || host_w_valid || |afu_r_valid || |afu_b_valid) begin
            report_failure("A valid output of the DUT is high right after reset");
        end
        write_burst(0, 32'h100, 4'd0);
        read_burst(0, 32'h100, 4'd0, at);
        for (int p = 1; p < NUM_PORTS; p++) begin
            if (b_got[p].size() != 0 || r_got[p].size() != 0) begin
                report_failure($sformatf("Port %0d got a response it never asked for", p));
            end
        end
    endtask

    task automatic test_parallel_reads();
        int at [NUM_PORTS];
        t_addr a;
        ar_log.delete();
        for (int p = 0; p < NUM_PORTS; p++) begin
            a = 32'h200 + t_addr'(p * 8);
            mem[a] = beat_word(p + 1, a);
            ref_mem[a] = mem[a];
        end
        fork
            read_burst(0, 32'h200, 4'd0, at[0]);
            read_burst(1, 32'h208, 4'd0, at[1]);
            read_burst(2, 32'h210, 4'd0, at[2]);
            read_burst(3, 32'h218, 4'd0, at[3]);
        join
        if (ar_log.size() != NUM_PORTS) begin
            report_failure("Host did not see exactly one AR per port");
        end
        foreach (ar_log[k]) begin
            check_vchan(ar_log[k].user[VCHAN_WIDTH-1:0],
                        t_vchan'((ar_log[k].addr - 32'h200) / 8), "host_ar.user");
        end
    endtask

    task automatic test_parallel_bursts();
        int    at;
        int    p;
        t_addr base;
        aw_log.delete();
        w_log.delete();
        fork
            write_burst(1, 32'h400, 4'd3);
            write_burst(2, 32'h500, 4'd3);
        join
        if (aw_log.size() != 2 || w_log.size() != 8) begin
            report_failure("Host did not see two AWs and eight W beats");
        end
        // Each group of four W beats must belong to one burst
        for (int k = 0; k < 2; k++) begin
            base = aw_log[k].addr;
            p = (base == 32'h400) ? 1 : 2;
            check_vchan(aw_log[k].user[VCHAN_WIDTH-1:0], t_vchan'(p), "host_aw.user");
            check_len(aw_log[k].len, 4'd3, "host_aw.len");
            for (int i = 0; i < 4; i++) begin
                check_data(w_log[k*4 + i].data, beat_word(p, base + t_addr'(i * 8)),
                           "host_w.data");
            end
        end
        read_burst(1, 32'h400, 4'd3, at);
        read_burst(2, 32'h500, 4'd3, at);
    endtask

    task automatic port_traffic(input int p);
        int    at;
        t_addr a;
        for (int k = 0; k < 4; k++) begin
            a = t_addr'(32'h1000 * (p + 1) + k * 64);
            write_burst(p, a, t_len'(k));
            read_burst(p, a, t_len'(k), at);
        end
    endtask

    task automatic test_random_traffic();
        throttle = 1'b1;
        fork
            port_traffic(0);
            port_traffic(1);
            port_traffic(2);
            port_traffic(3);
        join
        throttle = 1'b0;
        repeat (10) @(posedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (r_got[p].size() != 0 || b_got[p].size() != 0) begin
                report_failure($sformatf("Port %0d received extra responses", p));
            end
        end
    endtask

    task automatic test_ar_latency();
        int at;
        repeat (3) @(posedge clk);
        ar_log.delete();
        ar_cycle.delete();
        read_burst(2, 32'h208, 4'd0, at);
        if (ar_cycle.size() != 1 || ar_cycle[0] - at != 1) begin
            report_failure("Read address did not reach host_ar one cycle after the port");
        end
    endtask

    initial begin
        afu_ar_valid <= '0;
        afu_aw_valid <= '0;
        afu_w_valid  <= '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            afu_ar[p] <= '0;
            afu_aw[p] <= '0;
            afu_w[p]  <= '0;
        end
        @(posedge reset_n);
        test_reset_and_single();
        test_parallel_reads();
        test_parallel_bursts();
        test_random_traffic();
        test_ar_latency();
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (TEST_BEATS * CYCLES_PER_BEAT) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles",
                 TEST_BEATS * CYCLES_PER_BEAT);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- filelist.f
rtl/vchan_mem_pkg.sv
rtl/vchan_arbiter.sv
rtl/vchan_demux.sv
rtl/vchan_write_merge.sv
rtl/vchan_write_split.sv
rtl/vchan_mem_mux.sv
verification/tb_clock_gen.sv
verification/vchan_mem_properties.sv
verification/vchan_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module vchan_mem_tb \
    -f filelist.f \
    --Mdir obj_dir -o vchan_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/vchan_mem_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
